/* Bender.yml */
package:
  name: hss_framer

sources:
  # RTL in compile order
  - files:
      - rtl/hss_pkg.sv
      - rtl/frame_assembler.sv
      - rtl/crc_gen.sv
      - rtl/frame_checker.sv
      - rtl/hss_framer_top.sv

  # Testbench
  - target: test
    files:
      - tests/hss_framer_tb.sv

/* project.f */
rtl/hss_pkg.sv
rtl/frame_assembler.sv
rtl/crc_gen.sv
rtl/frame_checker.sv
rtl/hss_framer_top.sv
tests/hss_framer_tb.sv

/* rtl/crc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module crc_gen import hss_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Words from the assembler
  input  link_word_t asm_word,
  // Registered link output
  output link_word_t link_tx
);

  crc_t crc;
  crc_t crc_next;

  // ----------------------------------------------------------------------
  // Checksum datapath
  // ----------------------------------------------------------------------
  // Next checksum, combinational
  assign crc_next = next_crc16_d32(crc_view(asm_word), crc);

  // Running checksum per frame
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      crc <= CRC_INIT;
    end else if (asm_word.vld) begin
      // Restart after each trailer
      if (asm_word.last) begin
        crc <= CRC_INIT;
      end else begin
        crc <= crc_next;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Link output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      link_tx <= '0;
    end else begin
      link_tx.vld  <= asm_word.vld;
      link_tx.last <= asm_word.vld && asm_word.last;
      if (asm_word.last) begin
        // Checksum goes into the trailer's lower half
        link_tx.data <= {asm_word.data[31:16], crc_next};
      end else begin
        link_tx.data <= asm_word.data;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/frame_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_assembler import hss_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Payload strobe from the source
  input  logic       pld_vld,
  input  flit_t      pld_data,
  // High while the trailer is issued
  output logic       pld_busy,
  // Assembled link words towards the CRC generator
  output link_word_t asm_word
);

  // ----------------------------------------------------------------------
  // State
  // ----------------------------------------------------------------------
  typedef enum logic {
    PAYLOAD,
    TRAILER
  } asm_state_t;

  asm_state_t state;
  flit_idx_t  pld_cnt;
  seq_t       seq;
  logic       accept;
  logic       frame_full;

  // Busy only during the trailer cycle
  assign pld_busy = (state == TRAILER);

  // Strobes during busy are dropped
  assign accept = pld_vld && !pld_busy;

  // Seventh payload of the frame
  assign frame_full = (pld_cnt == flit_idx_t'(PLD_FLITS - 1));

  // ----------------------------------------------------------------------
  // Control and output register
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= PAYLOAD;
      pld_cnt  <= '0;
      seq      <= '0;
      asm_word <= '0;
    end else begin
      case (state)
        PAYLOAD: begin
          // Payload words go out as they arrive
          asm_word.vld  <= accept;
          asm_word.last <= 1'b0;
          asm_word.data <= pld_data;
          if (accept) begin
            if (frame_full) begin
              pld_cnt <= '0;
              state   <= TRAILER;
            end else begin
              pld_cnt <= pld_cnt + flit_idx_t'(1);
            end
          end
        end
        TRAILER: begin
          // Sequence number on top, checksum slot left at zero
          asm_word.vld  <= 1'b1;
          asm_word.last <= 1'b1;
          asm_word.data <= {seq, 16'h0000};
          seq           <= seq + seq_t'(1);
          state         <= PAYLOAD;
        end
        default: begin
          state <= PAYLOAD;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/frame_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_checker import hss_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Words from the link
  input  link_word_t link_rx,
  // Delivered payload
  output logic       rx_vld,
  output flit_t      rx_data,
  // Per-trailer result pulses
  output logic       frame_ok,
  output logic       frame_bad,
  output logic       seq_err,
  // Running counts
  output cnt_t       frame_count,
  output cnt_t       err_count
);

  crc_t crc;
  crc_t crc_calc;
  seq_t exp_seq;
  seq_t rx_seq;
  logic is_trailer;
  logic crc_bad;
  logic seq_bad;
  logic bad;

  // ----------------------------------------------------------------------
  // Checks, combinational
  // ----------------------------------------------------------------------
  // Same checksum as the transmitter
  assign crc_calc = next_crc16_d32(crc_view(link_rx), crc);

  assign is_trailer = link_rx.vld && link_rx.last;
  assign rx_seq     = link_rx.data[31:16];

  // Received checksum in the lower half
  assign crc_bad = (crc_calc != link_rx.data[15:0]);
  assign seq_bad = (rx_seq != exp_seq);
  assign bad     = crc_bad || seq_bad;

  // ----------------------------------------------------------------------
  // Checksum and sequence tracking
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      crc     <= CRC_INIT;
      exp_seq <= '0;
    end else if (link_rx.vld) begin
      if (link_rx.last) begin
        crc <= CRC_INIT;
        // Follow the received number, resync after a bad one
        exp_seq <= rx_seq + seq_t'(1);
      end else begin
        crc <= crc_calc;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Result pulses and counters
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rx_vld      <= 1'b0;
      frame_ok    <= 1'b0;
      frame_bad   <= 1'b0;
      seq_err     <= 1'b0;
      frame_count <= '0;
      err_count   <= '0;
    end else begin
      // Payload strobe, no wait for the check
      rx_vld <= link_rx.vld && !link_rx.last;
      // Single-cycle pulses
      frame_ok  <= is_trailer && !bad;
      frame_bad <= is_trailer && bad;
      seq_err   <= is_trailer && seq_bad;
      if (is_trailer) begin
        frame_count <= frame_count + cnt_t'(1);
        if (bad) begin
          err_count <= err_count + cnt_t'(1);
        end
      end
    end
  end

  // Payload data register
  always_ff @(posedge clk) begin
    if (link_rx.vld && !link_rx.last) begin
      rx_data <= link_rx.data;
    end
  end

endmodule

`default_nettype wire

/* rtl/hss_framer_top.sv */
`timescale 1ns/1ps
`default_nettype none

module hss_framer_top import hss_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  // Payload in
  input  logic       pld_vld,
  input  flit_t      pld_data,
  output logic       pld_busy,
  // Link
  output link_word_t link_tx,
  input  link_word_t link_rx,
  // Receive results
  output logic       rx_vld,
  output flit_t      rx_data,
  output logic       frame_ok,
  output logic       frame_bad,
  output logic       seq_err,
  output cnt_t       frame_count,
  output cnt_t       err_count
);

  // Assembler to CRC generator
  link_word_t asm_word;

  // ----------------------------------------------------------------------
  // Transmit path
  // ----------------------------------------------------------------------
  frame_assembler frame_assembler_inst (
    .clk      (clk),
    .rst      (rst),
    .pld_vld  (pld_vld),
    .pld_data (pld_data),
    .pld_busy (pld_busy),
    .asm_word (asm_word)
  );

  crc_gen crc_gen_inst (
    .clk      (clk),
    .rst      (rst),
    .asm_word (asm_word),
    .link_tx  (link_tx)
  );

  // ----------------------------------------------------------------------
  // Receive path
  // ----------------------------------------------------------------------
  frame_checker frame_checker_inst (
    .clk         (clk),
    .rst         (rst),
    .link_rx     (link_rx),
    .rx_vld      (rx_vld),
    .rx_data     (rx_data),
    .frame_ok    (frame_ok),
    .frame_bad   (frame_bad),
    .seq_err     (seq_err),
    .frame_count (frame_count),
    .err_count   (err_count)
  );

endmodule

`default_nettype wire

/* rtl/hss_pkg.sv */
`default_nettype none

package hss_pkg;

  // ----------------------------------------------------------------------
  // Widths with a meaning on the link
  // ----------------------------------------------------------------------
  // One link data word
  typedef logic [31:0] flit_t;
  // CRC-16 checksum
  typedef logic [15:0] crc_t;
  // Frame sequence number, upper half of the trailer
  typedef logic [15:0] seq_t;
  // Frame and error counters
  typedef logic [15:0] cnt_t;

  // ----------------------------------------------------------------------
  // Frame constants
  // ----------------------------------------------------------------------
  // Flits per frame, trailer included
  localparam int unsigned FRAME_FLITS = 8;
  // Payload flits per frame
  localparam int unsigned PLD_FLITS = FRAME_FLITS - 1;
  // Standard CRC start value
  localparam crc_t CRC_INIT = '1;

  // Index of a payload flit inside its frame
  typedef logic [$clog2(FRAME_FLITS)-1:0] flit_idx_t;

  // One link cycle
  typedef struct packed {
    logic  vld;
    // Trailer flit of a frame
    logic  last;
    flit_t data;
  } link_word_t;

  // ----------------------------------------------------------------------
  // CRC-16-CCITT, poly 0x1021, 32 data bits per step
  // ----------------------------------------------------------------------
  // Bit-serial form, unrolled by synthesis
  // Data bit 31 enters first
  function automatic crc_t next_crc16_d32(input flit_t data, input crc_t crc);
    crc_t c;
    logic fb;
    c = crc;
    for (int i = 31; i >= 0; i--) begin
      // Feedback from the top bit
      fb = c[15] ^ data[i];
      c = {c[14:0], 1'b0};
      if (fb) begin
        c = c ^ 16'h1021;
      end
    end
    return c;
  endfunction

  // Trailer as seen by the CRC, checksum field cleared
  function automatic flit_t crc_view(input link_word_t w);
    flit_t d;
    d = w.data;
    if (w.last) begin
      d[15:0] = '0;
    end
    return d;
  endfunction

endpackage

`default_nettype wire

/* tests/hss_framer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module hss_framer_tb import hss_pkg::*;;

  logic       clk;
  logic       rst;
  logic       pld_vld;
  flit_t      pld_data;
  logic       pld_busy;
  link_word_t link_tx;
  link_word_t link_rx;
  logic       rx_vld;
  flit_t      rx_data;
  logic       frame_ok;
  logic       frame_bad;
  logic       seq_err;
  cnt_t       frame_count;
  cnt_t       err_count;

  integer seed = 32'h0930100a;
  int     errors = 0;
  int     acc_cnt = 0;
  logic   busy_exp = 1'b0;
  cnt_t   m_frames = '0;
  cnt_t   m_errs = '0;
  seq_t   m_seq = '0;
  crc_t   m_crc = CRC_INIT;
  seq_t   frame_no = '0;
  // Expected link_tx payloads as {due cycle, data}
  logic [63:0] lat_q[$];
  logic [63:0] lat_head;
  flit_t       rx_q[$];
  flit_t       trl_q[$];
  flit_t       q_head;
  logic [31:0] cyc;
  // Loopback position tracking and error injection
  logic [2:0]  tx_pos;
  seq_t        tx_frame;
  crc_t        lb_crc;
  logic [1:0]  inj_mode;
  seq_t        inj_frame;
  logic [2:0]  inj_pos;
  logic [4:0]  inj_bit;
  seq_t        inj_seq;
  flit_t       inj_mask;

  hss_framer_top hss_framer_top_inst (
    .clk(clk), .rst(rst), .pld_vld(pld_vld), .pld_data(pld_data), .pld_busy(pld_busy),
    .link_tx(link_tx), .link_rx(link_rx), .rx_vld(rx_vld), .rx_data(rx_data),
    .frame_ok(frame_ok), .frame_bad(frame_bad), .seq_err(seq_err),
    .frame_count(frame_count), .err_count(err_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("Fail %0t: %s", $time, msg);
    errors++;
  endtask

  // Busy lasts one cycle, result pulses never both high
  assert property (@(posedge clk) disable iff (rst) pld_busy |=> !pld_busy)
    else report_fail("pld_busy high for more than one cycle");
  assert property (@(posedge clk) disable iff (rst) !(frame_ok && frame_bad))
    else report_fail("frame_ok and frame_bad together");

  // ----------------------------------------------------------------------
  // Loopback with bit flip or sequence replacement
  // ----------------------------------------------------------------------
  always_comb begin
    inj_mask = '0;
    link_rx = link_tx;
    if (link_tx.vld && tx_frame == inj_frame) begin
      if (inj_mode == 2'd1 && tx_pos == inj_pos) inj_mask = 32'd1 << inj_bit;
      // New sequence field, checksum made valid again
      if (inj_mode == 2'd2 && link_tx.last)
        link_rx.data = {inj_seq, next_crc16_d32({inj_seq, 16'h0000}, lb_crc)};
    end
    link_rx.data = link_rx.data ^ inj_mask;
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      cyc <= '0;
      tx_pos <= '0;
      tx_frame <= '0;
      lb_crc <= CRC_INIT;
    end else begin
      cyc <= cyc + 32'd1;
      if (link_tx.vld && link_tx.last) begin
        tx_pos <= '0;
        tx_frame <= tx_frame + seq_t'(1);
        lb_crc <= CRC_INIT;
      end else if (link_tx.vld) begin
        tx_pos <= tx_pos + 3'd1;
        lb_crc <= next_crc16_d32(link_tx.data, lb_crc);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Reference model, sampled at the falling edge
  // ----------------------------------------------------------------------
  always @(negedge clk) begin
    if (!rst) begin
      assert (pld_busy == busy_exp) else report_fail("pld_busy differs from model");
      busy_exp = 1'b0;
      // Accepted at the next rising edge, on link_tx two edges later
      if (pld_vld && !pld_busy) begin
        lat_q.push_back({cyc + 32'd2, pld_data});
        m_crc = next_crc16_d32(pld_data, m_crc);
        acc_cnt++;
        if (acc_cnt == PLD_FLITS) begin
          trl_q.push_back({m_seq, next_crc16_d32({m_seq, 16'h0000}, m_crc)});
          m_seq = m_seq + seq_t'(1);
          m_crc = CRC_INIT;
          acc_cnt = 0;
          busy_exp = 1'b1;
        end
      end
      if (rx_vld) begin
        if (rx_q.size() == 0) begin
          $display("Unexpected payload on rx_data at %0t", $time);
          errors++;
        end else begin
          q_head = rx_q.pop_front();
          assert (rx_data == q_head) else report_fail("rx_data wrong");
        end
      end
      if (link_tx.vld && !link_tx.last) begin
        assert (lat_q.size() > 0 && lat_q[0] == {cyc, link_tx.data})
          else report_fail("link_tx payload wrong or not 2 cycles after accept");
        if (lat_q.size() > 0) begin
          lat_head = lat_q.pop_front();
          rx_q.push_back(lat_head[31:0] ^ inj_mask);
        end
      end
      if (link_tx.vld && link_tx.last) begin
        if (trl_q.size() == 0) begin
          $display("Unexpected trailer on link_tx at %0t", $time);
          errors++;
        end else begin
          q_head = trl_q.pop_front();
          assert (link_tx.data == q_head)
            else report_fail("trailer sequence or CRC wrong");
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic send_frame();
    int sent;
    int t;
    int gap;
    sent = 0;
    // Line up with the drive point after the rising edge
    @(posedge clk);
    #1;
    inj_frame = frame_no;
    frame_no = frame_no + seq_t'(1);
    while (sent < PLD_FLITS) begin
      t = 0;
      while (pld_busy && t < 20) begin
        @(posedge clk);
        #1;
        t++;
      end
      if (pld_busy) begin
        $display("Timeout: pld_busy never dropped at %0t", $time);
        errors++;
        return;
      end
      pld_vld = 1'b1;
      pld_data = $random(seed);
      @(posedge clk);
      #1;
      pld_vld = 1'b0;
      sent++;
      // Idle gap of 0 to 3 cycles
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  task automatic wait_result(input logic exp_ok, input logic exp_seq);
    int t;
    t = 0;
    @(negedge clk);
    while (!(frame_ok || frame_bad) && t < 40) begin
      @(negedge clk);
      t++;
    end
    if (!(frame_ok || frame_bad)) begin
      $display("Timeout: no frame result seen at %0t", $time);
      errors++;
    end else begin
      m_frames = m_frames + cnt_t'(1);
      if (!exp_ok) m_errs = m_errs + cnt_t'(1);
      assert (frame_ok == exp_ok && frame_bad == !exp_ok && seq_err == exp_seq)
        else report_fail("frame result pulses wrong");
      assert (frame_count == m_frames && err_count == m_errs) else report_fail("counters wrong");
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    rst = 1'b1;
    pld_vld = 1'b0;
    pld_data = '0;
    inj_mode = 2'd0;
    inj_frame = '1;
    inj_pos = '0;
    inj_bit = '0;
    inj_seq = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    assert (!pld_busy && !link_tx.vld && !rx_vld && !frame_ok && !frame_bad && !seq_err
            && frame_count == 0 && err_count == 0) else report_fail("state after reset");
    $display("Test reset finished, %0d errors", errors);

    repeat (4) begin
      send_frame();
      wait_result(1'b1, 1'b0);
    end
    $display("Test clean frames finished, %0d errors", errors);

    // One flipped bit per flit position, then a clean frame
    for (int i = 0; i < FRAME_FLITS; i++) begin
      inj_mode = 2'd1;
      inj_pos = 3'(i);
      // Trailer flips stay in the checksum half
      inj_bit = (i == PLD_FLITS) ? 5'($unsigned($random(seed)) % 16) : 5'($random(seed));
      send_frame();
      wait_result(1'b0, 1'b0);
      inj_mode = 2'd0;
      send_frame();
      wait_result(1'b1, 1'b0);
    end
    $display("Test bit flips finished, %0d errors", errors);

    // Altered sequence, checker resyncs to it
    inj_mode = 2'd2;
    inj_seq = m_seq + seq_t'(16'h0100);
    send_frame();
    wait_result(1'b0, 1'b1);
    inj_mode = 2'd0;
    send_frame();
    wait_result(1'b0, 1'b1);
    send_frame();
    wait_result(1'b1, 1'b0);
    $display("Test sequence error finished, %0d errors", errors);

    repeat (5) @(negedge clk);
    assert (lat_q.size() == 0 && rx_q.size() == 0 && trl_q.size() == 0)
      else report_fail("words left over in model queues");
    $display("Summary: %0d frames, %0d bad frames, %0d errors", m_frames, m_errs, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
